// ==== src/mult_cfg_pkg.sv ====
package mult_cfg_pkg;

  // Operand and product width
  localparam int data_width = 64;

  // Pipeline depth of the multiplier
  localparam int num_stages = 4;

  // Multiplier bits consumed per stage
  localparam int bits_per_stage = data_width / num_stages;

  // Tag widths
  localparam int rob_idx_width  = 5;   // 32 ROB entries
  localparam int preg_idx_width = 6;
  localparam int areg_idx_width = 5;

  // Immediate literal, zero-extended to data_width
  localparam int literal_width = 8;

endpackage

// ==== src/mult_ops_pkg.sv ====
package mult_ops_pkg;

  // Source of operand B
  typedef enum logic {
    opb_is_reg     = 1'b0,
    opb_is_literal = 1'b1
  } opb_select_t;

  // Entry is younger than the rollback point and within the rollback depth.
  // The age difference wraps modulo the ROB size, so a plain subtraction in
  // rob_idx_width bits gives the distance from the mispredicted entry.
  function automatic logic rob_is_squashed(
    input logic [mult_cfg_pkg::rob_idx_width-1:0] entry_idx,
    input logic [mult_cfg_pkg::rob_idx_width-1:0] rollback_idx,
    input logic [mult_cfg_pkg::rob_idx_width-1:0] rollback_depth
  );
    logic [mult_cfg_pkg::rob_idx_width-1:0] age_diff;
    logic                                   is_younger;
    logic                                   in_window;

    age_diff   = entry_idx - rollback_idx;
    is_younger = (age_diff != '0);   // Mispredicted entry itself survives
    in_window  = (age_diff <= rollback_depth);
    return is_younger && in_window;
  endfunction

endpackage

// ==== src/mult_stage.sv ====
module mult_stage (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      advance,
  input  logic                                      in_valid,
  input  logic [mult_cfg_pkg::data_width-1:0]       in_product,
  input  logic [mult_cfg_pkg::data_width-1:0]       in_mplier,
  input  logic [mult_cfg_pkg::data_width-1:0]       in_mcand,
  input  logic [mult_cfg_pkg::areg_idx_width-1:0]   in_dest_reg,
  input  logic [mult_cfg_pkg::preg_idx_width-1:0]   in_dest_preg,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    in_rob_idx,
  input  logic                                      rollback_en,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rollback_idx,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rollback_depth,
  output logic                                      out_valid,
  output logic [mult_cfg_pkg::data_width-1:0]       out_product,
  output logic [mult_cfg_pkg::data_width-1:0]       out_mplier,
  output logic [mult_cfg_pkg::data_width-1:0]       out_mcand,
  output logic [mult_cfg_pkg::areg_idx_width-1:0]   out_dest_reg,
  output logic [mult_cfg_pkg::preg_idx_width-1:0]   out_dest_preg,
  output logic [mult_cfg_pkg::rob_idx_width-1:0]    out_rob_idx
);

  logic [mult_cfg_pkg::data_width-1:0]    partial_product;
  logic [mult_cfg_pkg::data_width-1:0]    next_product;
  logic [mult_cfg_pkg::data_width-1:0]    next_mplier;
  logic [mult_cfg_pkg::data_width-1:0]    next_mcand;
  logic [mult_cfg_pkg::rob_idx_width-1:0] held_rob_idx;
  logic                                   loaded_valid;
  logic                                   squash;
  logic                                   next_valid;

  // Low slice of the multiplier times the shifted multiplicand
  assign partial_product = in_mplier[mult_cfg_pkg::bits_per_stage-1:0] * in_mcand;
  assign next_product    = in_product + partial_product;

  assign next_mplier = in_mplier >> mult_cfg_pkg::bits_per_stage;
  assign next_mcand  = in_mcand << mult_cfg_pkg::bits_per_stage;

  // Entry this stage holds after the edge, incoming or kept
  assign held_rob_idx = advance ? in_rob_idx : out_rob_idx;
  assign loaded_valid = advance ? in_valid : out_valid;

  assign squash = rollback_en &&
                  mult_ops_pkg::rob_is_squashed(held_rob_idx, rollback_idx, rollback_depth);

  assign next_valid = loaded_valid && !squash;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= next_valid;
    end
  end

  // Payload moves only when the pipeline advances
  always_ff @(posedge clock) begin
    if (advance) begin
      out_product   <= next_product;
      out_mplier    <= next_mplier;
      out_mcand     <= next_mcand;
      out_dest_reg  <= in_dest_reg;
      out_dest_preg <= in_dest_preg;
      out_rob_idx   <= in_rob_idx;
    end
  end

endmodule

// ==== src/mult_result_port.sv ====
module mult_result_port (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      cdb_grant,
  input  logic                                      in_valid,
  input  logic [mult_cfg_pkg::data_width-1:0]       in_product,
  input  logic [mult_cfg_pkg::areg_idx_width-1:0]   in_dest_reg,
  input  logic [mult_cfg_pkg::preg_idx_width-1:0]   in_dest_preg,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    in_rob_idx,
  input  logic                                      rollback_en,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rollback_idx,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rollback_depth,
  output logic                                      advance,
  output logic                                      result_done,
  output logic [mult_cfg_pkg::data_width-1:0]       result_value,
  output logic [mult_cfg_pkg::areg_idx_width-1:0]   result_dest_reg,
  output logic [mult_cfg_pkg::preg_idx_width-1:0]   result_dest_preg,
  output logic [mult_cfg_pkg::rob_idx_width-1:0]    result_rob_idx
);

  logic [mult_cfg_pkg::rob_idx_width-1:0] held_rob_idx;
  logic                                   loaded_done;
  logic                                   squash;

  // Empty or being taken this cycle, so everything behind may move
  assign advance = !result_done || cdb_grant;

  assign held_rob_idx = advance ? in_rob_idx : result_rob_idx;
  assign loaded_done  = advance ? in_valid : result_done;

  // A result waiting for the bus can still be squashed
  assign squash = rollback_en &&
                  mult_ops_pkg::rob_is_squashed(held_rob_idx, rollback_idx, rollback_depth);

  always_ff @(posedge clock) begin
    if (reset) begin
      result_done <= 1'b0;
    end else begin
      result_done <= loaded_done && !squash;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      result_value     <= in_product;
      result_dest_reg  <= in_dest_reg;
      result_dest_preg <= in_dest_preg;
      result_rob_idx   <= in_rob_idx;
    end
  end

endmodule

// ==== src/mult_unit.sv ====
module mult_unit (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      issue_valid,
  input  logic [mult_cfg_pkg::data_width-1:0]       opa_value,
  input  logic [mult_cfg_pkg::data_width-1:0]       opb_reg_value,
  input  logic [mult_cfg_pkg::literal_width-1:0]    opb_literal,
  input  mult_ops_pkg::opb_select_t                 opb_select,
  input  logic [mult_cfg_pkg::areg_idx_width-1:0]   dest_reg,
  input  logic [mult_cfg_pkg::preg_idx_width-1:0]   dest_preg,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rob_idx,
  input  logic                                      rollback_en,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rollback_idx,
  input  logic [mult_cfg_pkg::rob_idx_width-1:0]    rollback_depth,
  input  logic                                      cdb_grant,
  output logic                                      issue_ready,
  output logic                                      result_done,
  output logic [mult_cfg_pkg::data_width-1:0]       result_value,
  output logic [mult_cfg_pkg::areg_idx_width-1:0]   result_dest_reg,
  output logic [mult_cfg_pkg::preg_idx_width-1:0]   result_dest_preg,
  output logic [mult_cfg_pkg::rob_idx_width-1:0]    result_rob_idx
);

  // Index 0 is the issue side, index num_stages feeds the result port
  logic                                   valid_chain     [mult_cfg_pkg::num_stages+1];
  logic [mult_cfg_pkg::data_width-1:0]    product_chain   [mult_cfg_pkg::num_stages+1];
  logic [mult_cfg_pkg::data_width-1:0]    mplier_chain    [mult_cfg_pkg::num_stages+1];
  logic [mult_cfg_pkg::data_width-1:0]    mcand_chain     [mult_cfg_pkg::num_stages+1];
  logic [mult_cfg_pkg::areg_idx_width-1:0] dest_reg_chain [mult_cfg_pkg::num_stages+1];
  logic [mult_cfg_pkg::preg_idx_width-1:0] dest_preg_chain [mult_cfg_pkg::num_stages+1];
  logic [mult_cfg_pkg::rob_idx_width-1:0] rob_idx_chain   [mult_cfg_pkg::num_stages+1];

  logic [mult_cfg_pkg::data_width-1:0]    opb_value;
  logic                                   advance;

  always_comb begin
    case (opb_select)
      mult_ops_pkg::opb_is_literal:
        opb_value = {{(mult_cfg_pkg::data_width-mult_cfg_pkg::literal_width){1'b0}},
                     opb_literal};   // Zero-extended
      default:
        opb_value = opb_reg_value;
    endcase
  end

  assign issue_ready = advance;

  assign valid_chain[0]     = issue_valid;
  assign product_chain[0]   = '0;
  assign mplier_chain[0]    = opa_value;
  assign mcand_chain[0]     = opb_value;
  assign dest_reg_chain[0]  = dest_reg;
  assign dest_preg_chain[0] = dest_preg;
  assign rob_idx_chain[0]   = rob_idx;

  genvar i;
  generate
    for (i = 0; i < mult_cfg_pkg::num_stages; i++) begin : g_stage
      mult_stage stage (
        .clock          (clock),
        .reset          (reset),
        .advance        (advance),
        .in_valid       (valid_chain[i]),
        .in_product     (product_chain[i]),
        .in_mplier      (mplier_chain[i]),
        .in_mcand       (mcand_chain[i]),
        .in_dest_reg    (dest_reg_chain[i]),
        .in_dest_preg   (dest_preg_chain[i]),
        .in_rob_idx     (rob_idx_chain[i]),
        .rollback_en    (rollback_en),
        .rollback_idx   (rollback_idx),
        .rollback_depth (rollback_depth),
        .out_valid      (valid_chain[i+1]),
        .out_product    (product_chain[i+1]),
        .out_mplier     (mplier_chain[i+1]),
        .out_mcand      (mcand_chain[i+1]),
        .out_dest_reg   (dest_reg_chain[i+1]),
        .out_dest_preg  (dest_preg_chain[i+1]),
        .out_rob_idx    (rob_idx_chain[i+1])
      );
    end
  endgenerate

  // Holds the finished product until the result bus takes it
  mult_result_port result_port (
    .clock            (clock),
    .reset            (reset),
    .cdb_grant        (cdb_grant),
    .in_valid         (valid_chain[mult_cfg_pkg::num_stages]),
    .in_product       (product_chain[mult_cfg_pkg::num_stages]),
    .in_dest_reg      (dest_reg_chain[mult_cfg_pkg::num_stages]),
    .in_dest_preg     (dest_preg_chain[mult_cfg_pkg::num_stages]),
    .in_rob_idx       (rob_idx_chain[mult_cfg_pkg::num_stages]),
    .rollback_en      (rollback_en),
    .rollback_idx     (rollback_idx),
    .rollback_depth   (rollback_depth),
    .advance          (advance),
    .result_done      (result_done),
    .result_value     (result_value),
    .result_dest_reg  (result_dest_reg),
    .result_dest_preg (result_dest_preg),
    .result_rob_idx   (result_rob_idx)
  );

endmodule

// ==== test/mult_model.svh ====
`ifndef mult_model_svh
`define mult_model_svh

localparam int rob_entries = 1 << mult_cfg_pkg::rob_idx_width;

// Accepted entries not yet taken from the result bus, oldest first
logic [mult_cfg_pkg::data_width-1:0]     model_value_q     [$];
logic [mult_cfg_pkg::areg_idx_width-1:0] model_dest_reg_q  [$];
logic [mult_cfg_pkg::preg_idx_width-1:0] model_dest_preg_q [$];
logic [mult_cfg_pkg::rob_idx_width-1:0]  model_rob_idx_q   [$];

// Operand B as the issue side selects it
function automatic logic [mult_cfg_pkg::data_width-1:0] operand_b(
  input mult_ops_pkg::opb_select_t               sel,
  input logic [mult_cfg_pkg::data_width-1:0]     reg_value,
  input logic [mult_cfg_pkg::literal_width-1:0]  literal
);
  logic [mult_cfg_pkg::data_width-1:0] value;
  if (sel == mult_ops_pkg::opb_is_literal) begin
    value = '0;
    value[mult_cfg_pkg::literal_width-1:0] = literal;   // Zero-extended
  end else begin
    value = reg_value;
  end
  return value;
endfunction

// Full double-width product, low half kept
function automatic logic [63:0] expected_product(input logic [63:0] a, input logic [63:0] b);
  logic [127:0] full;
  full = {64'b0, a} * {64'b0, b};
  return full[63:0];
endfunction

// Ages count modulo the ROB size, the mispredicted entry itself stays
function automatic bit younger_in_window(input int entry_idx, input int rollback_idx,
                                         input int depth);
  int age;
  age = (entry_idx - rollback_idx + rob_entries) % rob_entries;
  return (age > 0) && (age <= depth);
endfunction

function automatic int model_count();
  return model_value_q.size();
endfunction

task automatic model_accept(input logic [63:0] value, input logic [4:0] dest_reg,
                            input logic [5:0] dest_preg, input logic [4:0] rob_idx);
  model_value_q.push_back(value);
  model_dest_reg_q.push_back(dest_reg);
  model_dest_preg_q.push_back(dest_preg);
  model_rob_idx_q.push_back(rob_idx);
endtask

task automatic model_retire();
  void'(model_value_q.pop_front());
  void'(model_dest_reg_q.pop_front());
  void'(model_dest_preg_q.pop_front());
  void'(model_rob_idx_q.pop_front());
endtask

task automatic model_rollback(input logic [4:0] rb_idx, input logic [4:0] depth,
                              output int removed);
  removed = 0;
  for (int i = model_value_q.size() - 1; i >= 0; i--) begin
    if (younger_in_window(int'(model_rob_idx_q[i]), int'(rb_idx), int'(depth))) begin
      model_value_q.delete(i);
      model_dest_reg_q.delete(i);
      model_dest_preg_q.delete(i);
      model_rob_idx_q.delete(i);
      removed++;
    end
  end
endtask

`endif

// ==== test/mult_unit_tb.sv ====
module mult_unit_tb;

  localparam int drive_delay         = 10;
  localparam int reset_cycles        = 8;
  localparam int latency_limit       = 20;
  localparam int product_cycles      = 200;
  localparam int backpressure_cycles = 300;
  localparam int rollback_cycles     = 300;
  localparam int drain_limit         = 20;
  localparam int timeout_cycles      = 8 * (reset_cycles + latency_limit + product_cycles +
                                            backpressure_cycles + rollback_cycles + drain_limit);

  logic                                    clock;
  logic                                    reset;
  logic                                    issue_valid;
  logic [mult_cfg_pkg::data_width-1:0]     opa_value;
  logic [mult_cfg_pkg::data_width-1:0]     opb_reg_value;
  logic [mult_cfg_pkg::literal_width-1:0]  opb_literal;
  mult_ops_pkg::opb_select_t               opb_select;
  logic [mult_cfg_pkg::areg_idx_width-1:0] dest_reg;
  logic [mult_cfg_pkg::preg_idx_width-1:0] dest_preg;
  logic [mult_cfg_pkg::rob_idx_width-1:0]  rob_idx;
  logic                                    rollback_en;
  logic [mult_cfg_pkg::rob_idx_width-1:0]  rollback_idx;
  logic [mult_cfg_pkg::rob_idx_width-1:0]  rollback_depth;
  logic                                    cdb_grant;
  logic                                    issue_ready;
  logic                                    result_done;
  logic [mult_cfg_pkg::data_width-1:0]     result_value;
  logic [mult_cfg_pkg::areg_idx_width-1:0] result_dest_reg;
  logic [mult_cfg_pkg::preg_idx_width-1:0] result_dest_preg;
  logic [mult_cfg_pkg::rob_idx_width-1:0]  result_rob_idx;

  integer seed;
  int     value_errors;
  int     other_errors;
  int     cycle_count;
  int     results_seen;
  int     squashed_total;
  string  phase_name;

  logic                                    prev_held;   // Done and not granted last cycle
  logic [mult_cfg_pkg::data_width-1:0]     prev_value;
  logic [mult_cfg_pkg::rob_idx_width-1:0]  prev_rob_idx;

  `include "mult_model.svh"

  mult_unit uut (
    .clock            (clock),
    .reset            (reset),
    .issue_valid      (issue_valid),
    .opa_value        (opa_value),
    .opb_reg_value    (opb_reg_value),
    .opb_literal      (opb_literal),
    .opb_select       (opb_select),
    .dest_reg         (dest_reg),
    .dest_preg        (dest_preg),
    .rob_idx          (rob_idx),
    .rollback_en      (rollback_en),
    .rollback_idx     (rollback_idx),
    .rollback_depth   (rollback_depth),
    .cdb_grant        (cdb_grant),
    .issue_ready      (issue_ready),
    .result_done      (result_done),
    .result_value     (result_value),
    .result_dest_reg  (result_dest_reg),
    .result_dest_preg (result_dest_preg),
    .result_rob_idx   (result_rob_idx)
  );

  always #50 clock = ~clock;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("** Error in %s, %s: expected %0h, actual %0h", phase_name, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("Failure in %s: %s", phase_name, what);
  endtask

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  task automatic drive_idle();
    issue_valid = 1'b0;
    cdb_grant   = 1'b1;
    rollback_en = 1'b0;
  endtask

  task automatic drive_random(input int issue_pct, input int grant_pct, input int rollback_pct);
    logic [31:0] r;
    issue_valid   = chance(issue_pct);
    opa_value     = {$random(seed), $random(seed)};
    opb_reg_value = {$random(seed), $random(seed)};
    r = $random(seed);
    opb_literal = r[7:0];
    opb_select  = r[8] ? mult_ops_pkg::opb_is_literal : mult_ops_pkg::opb_is_reg;
    dest_reg    = r[13:9];
    dest_preg   = r[19:14];
    rob_idx     = r[24:20];
    r = $random(seed);
    rollback_idx   = r[4:0];
    rollback_depth = r[9:5];
    cdb_grant   = chance(grant_pct);
    rollback_en = chance(rollback_pct);
  endtask

  task automatic run_cycles(input int cycles, input int issue_pct, input int grant_pct,
                            input int rollback_pct);
    repeat (cycles) begin
      @(posedge clock);
      #drive_delay;
      drive_random(issue_pct, grant_pct, rollback_pct);
    end
  endtask

  task automatic finish_run();
    $display("Results %0d, squashed %0d, value errors %0d, other errors %0d",
             results_seen, squashed_total, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // Inputs are stable here, so this sees what the next edge will do
  always @(negedge clock) begin
    int removed;
    if (!reset) begin
      check_value("issue_ready", !result_done || cdb_grant, issue_ready);
      if (prev_held && result_done) begin
        check_value("held result_value", prev_value, result_value);
        check_value("held result_rob_idx", prev_rob_idx, result_rob_idx);
      end
      if (result_done) begin
        if (model_count() == 0) begin
          report_failure("result_done is high with no entry in flight");
        end else begin
          check_value("result_value", model_value_q[0], result_value);
          check_value("result_dest_reg", model_dest_reg_q[0], result_dest_reg);
          check_value("result_dest_preg", model_dest_preg_q[0], result_dest_preg);
          check_value("result_rob_idx", model_rob_idx_q[0], result_rob_idx);
        end
      end
      if (result_done && cdb_grant && model_count() > 0) begin
        model_retire();
        results_seen++;
      end
      if (issue_valid && issue_ready) begin
        model_accept(expected_product(opa_value, operand_b(opb_select, opb_reg_value,
                     opb_literal)), dest_reg, dest_preg, rob_idx);
      end
      if (rollback_en) begin
        model_rollback(rollback_idx, rollback_depth, removed);
        squashed_total += removed;
      end
      prev_held    = result_done && !cdb_grant;
      prev_value   = result_value;
      prev_rob_idx = result_rob_idx;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    report_failure("the run did not finish within the cycle limit");
    finish_run();
  end

  initial begin
    int waited;
    seed           = 32'h3a3529a9;
    value_errors   = 0;
    other_errors   = 0;
    results_seen   = 0;
    squashed_total = 0;
    prev_held      = 1'b0;
    prev_value     = '0;
    prev_rob_idx   = '0;
    clock          = 1'b0;
    reset          = 1'b1;
    opa_value      = '0;
    opb_reg_value  = '0;
    opb_literal    = '0;
    opb_select     = mult_ops_pkg::opb_is_reg;
    dest_reg       = '0;
    dest_preg      = '0;
    rob_idx        = '0;
    rollback_idx   = '0;
    rollback_depth = '0;
    drive_idle();

    phase_name = "reset";
    repeat (reset_cycles) @(posedge clock);
    #drive_delay;
    reset = 1'b0;
    check_value("result_done", 1'b0, result_done);
    check_value("issue_ready", 1'b1, issue_ready);

    // Single entry through an empty pipeline
    phase_name = "latency";
    @(posedge clock);
    #drive_delay;
    drive_random(100, 100, 0);
    @(posedge clock);   // Accepted here
    #drive_delay;
    drive_idle();
    waited = 1;   // Acceptance edge loads the first stage
    while (!result_done && waited < latency_limit) begin
      @(posedge clock);
      #drive_delay;
      waited++;
    end
    if (!result_done) begin
      report_failure("no result appeared after a single issue");
    end else begin
      check_value("cycles to result_done", mult_cfg_pkg::num_stages + 1, waited);
    end

    phase_name = "random products";
    run_cycles(product_cycles, 100, 100, 0);

    phase_name = "back-pressure";
    run_cycles(backpressure_cycles, 75, 50, 0);

    phase_name = "rollback";
    run_cycles(rollback_cycles, 75, 75, 15);

    phase_name = "drain";
    @(posedge clock);
    #drive_delay;
    drive_idle();
    waited = 0;
    while ((model_count() != 0 || result_done) && waited < drain_limit) begin
      @(posedge clock);
      #drive_delay;
      waited++;
    end
    if (model_count() != 0) begin
      report_failure("accepted entries never reached the result bus");
    end
    finish_run();
  end

endmodule

// ==== sim.f ====
+incdir+test
src/mult_cfg_pkg.sv
src/mult_ops_pkg.sv
src/mult_stage.sv
src/mult_result_port.sv
src/mult_unit.sv
test/mult_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module mult_unit_tb -f sim.f -o mult_unit_tb \
  || { echo "Verilator build did not complete"; exit 1; }
./obj_dir/mult_unit_tb 2>&1 | tee sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0
